// ==== rvv_vrf_cfg_pkg.sv ====
/*
  Vector register file configuration
  Geometry of the 32-entry VRF and the row type shared by the
  register file, the load write-back collector and the debug slave
*/
package rvv_vrf_cfg_pkg;

  // Register geometry
  parameter int VLEN       = 128;
  parameter int VLENB      = VLEN / 8;
  parameter int VREG_NUM   = 32;
  parameter int VREG_IDX_W = $clog2(VREG_NUM);

  // Word view, matches the load beat and the APB data width
  parameter int WORD_W        = 32;
  parameter int WORD_B        = WORD_W / 8;
  parameter int WORDS_PER_ROW = VLEN / WORD_W;

  // One register row, seen flat, per byte or per 32-bit word
  typedef union packed {
    logic [VLEN-1:0]                       flat;
    logic [VLENB-1:0][7:0]                 bytes;
    logic [WORDS_PER_ROW-1:0][WORD_W-1:0]  words;
  } vrow_u;

endpackage

// ==== rvv_vrf_dbg_pkg.sv ====
/*
  VRF debug address map
  Host view of the register file as 32-bit words behind APB
*/
package rvv_vrf_dbg_pkg;

  parameter int DBG_ADDR_W = 12;
  parameter int DBG_DATA_W = rvv_vrf_cfg_pkg::WORD_W;
  parameter int DBG_STRB_W = DBG_DATA_W / 8;

  // Byte address layout: [8:4] register, [3:2] word in row
  parameter int DBG_WSEL_LSB = 2;
  parameter int DBG_WSEL_W   = $clog2(rvv_vrf_cfg_pkg::WORDS_PER_ROW);
  parameter int DBG_IDX_LSB  = DBG_WSEL_LSB + DBG_WSEL_W;

  // First byte address past the last register
  parameter logic [DBG_ADDR_W-1:0] DBG_ADDR_LIMIT = 12'h200;

endpackage

// ==== rvv_vrf_reg.sv ====
/*
  VRF storage array
  32 rows of VLEN bits, each byte written under its own enable
*/
`timescale 1ns/1ps

module rvv_vrf_reg (
  input  logic clk,
  input  logic arst_n,
  input  logic [rvv_vrf_cfg_pkg::VREG_NUM-1:0][rvv_vrf_cfg_pkg::VLENB-1:0] wenb,
  input  logic [rvv_vrf_cfg_pkg::VREG_NUM-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]  wdata,
  output logic [rvv_vrf_cfg_pkg::VREG_NUM-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]  vreg
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vreg <= '0;
    end else begin
      for (int r = 0; r < rvv_vrf_cfg_pkg::VREG_NUM; r++) begin
        for (int b = 0; b < rvv_vrf_cfg_pkg::VLENB; b++) begin
          if (wenb[r][b]) begin
            vreg[r][b*8 +: 8] <= wdata[r][b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== rvv_vrf.sv ====
/*
  Vector register file
  Merges the retire ports and the shared port into per-register byte
  enables, drives the storage and the dispatch, debug and v0 reads
*/
`timescale 1ns/1ps

module rvv_vrf #(
  parameter int NUM_RT = 4,
  parameter int NUM_RD = 4
) (
  input  logic clk,
  input  logic arst_n,

  input  logic [NUM_RT-1:0]                                  rt_wr_valid,
  input  logic [NUM_RT-1:0][rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] rt_wr_index,
  input  logic [NUM_RT-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]       rt_wr_data,
  input  logic [NUM_RT-1:0][rvv_vrf_cfg_pkg::VLENB-1:0]      rt_wr_strobe,

  input  logic                                  sh_wr_valid,
  input  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] sh_wr_index,
  input  rvv_vrf_cfg_pkg::vrow_u                sh_wr_data,
  input  logic [rvv_vrf_cfg_pkg::VLENB-1:0]      sh_wr_strobe,

  input  logic [NUM_RD-1:0][rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] rd_index,
  output logic [NUM_RD-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]       rd_data,

  input  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] dbg_rd_index,
  output rvv_vrf_cfg_pkg::vrow_u                dbg_rd_data,

  output logic [rvv_vrf_cfg_pkg::VLEN-1:0] v0_data
);

  // Retire ports first, shared port on top
  localparam int NUM_WR = NUM_RT + 1;

  logic [NUM_WR-1:0]                                  wr_valid;
  logic [NUM_WR-1:0][rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] wr_index;
  logic [NUM_WR-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]       wr_data;
  logic [NUM_WR-1:0][rvv_vrf_cfg_pkg::VLENB-1:0]      wr_strobe;

  logic [rvv_vrf_cfg_pkg::VREG_NUM-1:0][rvv_vrf_cfg_pkg::VLENB-1:0] wenb;
  logic [rvv_vrf_cfg_pkg::VREG_NUM-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]  wdata;
  logic [rvv_vrf_cfg_pkg::VREG_NUM-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]  vreg;

  assign wr_valid  = {sh_wr_valid, rt_wr_valid};
  assign wr_index  = {sh_wr_index, rt_wr_index};
  assign wr_data   = {sh_wr_data.flat, rt_wr_data};
  assign wr_strobe = {sh_wr_strobe, rt_wr_strobe};

  // Per-port decode, OR-merged per byte across ports
  always_comb begin
    rvv_vrf_cfg_pkg::vrow_u masked;
    wenb  = '0;
    wdata = '0;
    for (int p = 0; p < NUM_WR; p++) begin
      masked.flat = wr_data[p];
      for (int b = 0; b < rvv_vrf_cfg_pkg::VLENB; b++) begin
        if (!wr_strobe[p][b]) begin
          masked.bytes[b] = 8'h00;
        end
      end
      if (wr_valid[p]) begin
        wenb[wr_index[p]]  = wenb[wr_index[p]] | wr_strobe[p];
        wdata[wr_index[p]] = wdata[wr_index[p]] | masked.flat;
      end
    end
  end

  rvv_vrf_reg u_vrf_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .wenb   (wenb),
    .wdata  (wdata),
    .vreg   (vreg)
  );

  // Combinational reads
  for (genvar i = 0; i < NUM_RD; i++) begin : g_rd
    assign rd_data[i] = vreg[rd_index[i]];
  end

  assign dbg_rd_data = vreg[dbg_rd_index];
  assign v0_data     = vreg[0];

endmodule

// ==== rvv_vrf_wr_arb.sv ====
/*
  Shared write port arbiter
  Round-robin between the load write-back and the debug slave
*/
`timescale 1ns/1ps

module rvv_vrf_wr_arb (
  input  logic clk,
  input  logic arst_n,

  input  logic                                  ld_req,
  input  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] ld_index,
  input  rvv_vrf_cfg_pkg::vrow_u                ld_row,
  input  logic [rvv_vrf_cfg_pkg::VLENB-1:0]      ld_strobe,

  input  logic                                  dbg_req,
  input  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] dbg_index,
  input  rvv_vrf_cfg_pkg::vrow_u                dbg_row,
  input  logic [rvv_vrf_cfg_pkg::VLENB-1:0]      dbg_strobe,

  output logic ld_gnt,
  output logic dbg_gnt,

  output logic                                  sh_wr_valid,
  output logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] sh_wr_index,
  output rvv_vrf_cfg_pkg::vrow_u                sh_wr_data,
  output logic [rvv_vrf_cfg_pkg::VLENB-1:0]      sh_wr_strobe
);

  // Set when debug held the port last, so load wins the next tie
  logic last_dbg;

  assign ld_gnt  = ld_req & (~dbg_req | last_dbg);
  assign dbg_gnt = dbg_req & (~ld_req | ~last_dbg);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_dbg <= 1'b0;
    end else if (ld_gnt || dbg_gnt) begin
      last_dbg <= dbg_gnt;
    end
  end

  assign sh_wr_valid  = ld_gnt | dbg_gnt;
  assign sh_wr_index  = dbg_gnt ? dbg_index : ld_index;
  assign sh_wr_data   = dbg_gnt ? dbg_row : ld_row;
  assign sh_wr_strobe = dbg_gnt ? dbg_strobe : ld_strobe;

endmodule

// ==== rvv_vld_wb.sv ====
/*
  Vector load write-back collector
  Packs 32-bit load beats into one register row and writes it
  through the shared VRF port
*/
`timescale 1ns/1ps

module rvv_vld_wb (
  input  logic clk,
  input  logic arst_n,

  input  logic                                  ld_valid,
  input  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] ld_index,
  input  logic [rvv_vrf_cfg_pkg::WORD_W-1:0]     ld_data,
  input  logic                                  ld_last,
  output logic                                  ld_ready,

  output logic                                  req,
  output logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] index,
  output rvv_vrf_cfg_pkg::vrow_u                row,
  output logic [rvv_vrf_cfg_pkg::VLENB-1:0]      strobe,
  input  logic                                  gnt
);

  localparam int CNT_W = $clog2(rvv_vrf_cfg_pkg::WORDS_PER_ROW);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(rvv_vrf_cfg_pkg::WORDS_PER_ROW - 1);

  logic [CNT_W-1:0]                           cnt;
  logic [rvv_vrf_cfg_pkg::WORDS_PER_ROW-1:0] wvld;
  logic                                       beat;

  // No new beats while the row waits for the port
  assign ld_ready = ~req;
  assign beat     = ld_valid & ld_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt  <= '0;
      wvld <= '0;
      req  <= 1'b0;
    end else if (req && gnt) begin
      req  <= 1'b0;
      wvld <= '0;
    end else if (beat) begin
      wvld[cnt] <= 1'b1;
      if (ld_last || cnt == LAST_WORD) begin
        req <= 1'b1;
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // Row payload, index taken from the first beat
  always_ff @(posedge clk) begin
    if (beat) begin
      row.words[cnt] <= ld_data;
      if (cnt == '0) begin
        index <= ld_index;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < rvv_vrf_cfg_pkg::WORDS_PER_ROW; w++) begin
      strobe[w*rvv_vrf_cfg_pkg::WORD_B +: rvv_vrf_cfg_pkg::WORD_B] =
        {rvv_vrf_cfg_pkg::WORD_B{wvld[w]}};
    end
  end

endmodule

// ==== rvv_vrf_dbg_apb.sv ====
/*
  APB3 debug slave for the VRF
  Host word reads through the debug read port, word writes through
  the shared write port
*/
`timescale 1ns/1ps

module rvv_vrf_dbg_apb (
  input  logic clk,
  input  logic arst_n,

  input  logic                                     psel,
  input  logic                                     penable,
  input  logic                                     pwrite,
  input  logic [rvv_vrf_dbg_pkg::DBG_ADDR_W-1:0]   paddr,
  input  logic [rvv_vrf_dbg_pkg::DBG_DATA_W-1:0]   pwdata,
  input  logic [rvv_vrf_dbg_pkg::DBG_STRB_W-1:0]   pstrb,
  output logic [rvv_vrf_dbg_pkg::DBG_DATA_W-1:0]   prdata,
  output logic                                     pready,
  output logic                                     pslverr,

  output logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0]   rd_index,
  input  rvv_vrf_cfg_pkg::vrow_u                  rd_data,

  output logic                                     req,
  output logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0]   index,
  output rvv_vrf_cfg_pkg::vrow_u                  row,
  output logic [rvv_vrf_cfg_pkg::VLENB-1:0]        strobe,
  input  logic                                     gnt
);

  logic                                        setup;
  logic                                        access;
  logic [rvv_vrf_dbg_pkg::DBG_WSEL_W-1:0]      wsel;
  logic [rvv_vrf_dbg_pkg::DBG_WSEL_W-1:0]      wsel_q;
  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0]      idx_q;
  logic                                        wr_q;
  logic                                        err_q;

  assign setup  = psel & ~penable;
  assign access = psel & penable;
  assign wsel   = paddr[rvv_vrf_dbg_pkg::DBG_WSEL_LSB +: rvv_vrf_dbg_pkg::DBG_WSEL_W];

  // Decode in setup so the row is already on the read port in access
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_q  <= 1'b0;
      err_q <= 1'b0;
    end else if (setup) begin
      wr_q  <= pwrite;
      err_q <= (paddr >= rvv_vrf_dbg_pkg::DBG_ADDR_LIMIT);
    end
  end

  always_ff @(posedge clk) begin
    if (setup) begin
      idx_q  <= paddr[rvv_vrf_dbg_pkg::DBG_IDX_LSB +: rvv_vrf_cfg_pkg::VREG_IDX_W];
      wsel_q <= wsel;
      // One-word row, strobes only in the addressed word
      for (int w = 0; w < rvv_vrf_cfg_pkg::WORDS_PER_ROW; w++) begin
        row.words[w] <= (wsel == w) ? pwdata : '0;
        strobe[w*rvv_vrf_cfg_pkg::WORD_B +: rvv_vrf_cfg_pkg::WORD_B] <=
          (wsel == w) ? pstrb : '0;
      end
    end
  end

  assign rd_index = idx_q;
  assign index    = idx_q;
  assign prdata   = rd_data.words[wsel_q];

  // Reads and errors finish in the first access cycle, writes on grant
  assign req     = access & wr_q & ~err_q;
  assign pready  = access & (~wr_q | err_q | gnt);
  assign pslverr = access & err_q;

endmodule

// ==== rvv_vrf_top.sv ====
/*
  VRF subsystem top
  Register file with retire and dispatch ports, plus a shared write
  port for the load write-back and the APB debug slave
*/
`timescale 1ns/1ps

module rvv_vrf_top #(
  parameter int NUM_RT = 4,
  parameter int NUM_RD = 4
) (
  input  logic clk,
  input  logic arst_n,

  input  logic [NUM_RT-1:0]                                  rt_wr_valid,
  input  logic [NUM_RT-1:0][rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] rt_wr_index,
  input  logic [NUM_RT-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]       rt_wr_data,
  input  logic [NUM_RT-1:0][rvv_vrf_cfg_pkg::VLENB-1:0]      rt_wr_strobe,

  input  logic [NUM_RD-1:0][rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] rd_index,
  output logic [NUM_RD-1:0][rvv_vrf_cfg_pkg::VLEN-1:0]       rd_data,
  output logic [rvv_vrf_cfg_pkg::VLEN-1:0]                   v0_data,

  input  logic                                  ld_valid,
  output logic                                  ld_ready,
  input  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] ld_index,
  input  logic [rvv_vrf_cfg_pkg::WORD_W-1:0]     ld_data,
  input  logic                                  ld_last,

  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [rvv_vrf_dbg_pkg::DBG_ADDR_W-1:0] paddr,
  input  logic [rvv_vrf_dbg_pkg::DBG_DATA_W-1:0] pwdata,
  input  logic [rvv_vrf_dbg_pkg::DBG_STRB_W-1:0] pstrb,
  output logic [rvv_vrf_dbg_pkg::DBG_DATA_W-1:0] prdata,
  output logic                                   pready,
  output logic                                   pslverr
);

  logic                                  ld_req, ld_gnt, dbg_req, dbg_gnt;
  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] ld_wr_index, dbg_wr_index, dbg_rd_index;
  rvv_vrf_cfg_pkg::vrow_u                ld_wr_row, dbg_wr_row, dbg_rd_data;
  logic [rvv_vrf_cfg_pkg::VLENB-1:0]      ld_wr_strobe, dbg_wr_strobe;

  logic                                  sh_wr_valid;
  logic [rvv_vrf_cfg_pkg::VREG_IDX_W-1:0] sh_wr_index;
  rvv_vrf_cfg_pkg::vrow_u                sh_wr_data;
  logic [rvv_vrf_cfg_pkg::VLENB-1:0]      sh_wr_strobe;

  rvv_vrf #(
    .NUM_RT (NUM_RT),
    .NUM_RD (NUM_RD)
  ) u_vrf (
    .clk          (clk),
    .arst_n       (arst_n),
    .rt_wr_valid  (rt_wr_valid),
    .rt_wr_index  (rt_wr_index),
    .rt_wr_data   (rt_wr_data),
    .rt_wr_strobe (rt_wr_strobe),
    .sh_wr_valid  (sh_wr_valid),
    .sh_wr_index  (sh_wr_index),
    .sh_wr_data   (sh_wr_data),
    .sh_wr_strobe (sh_wr_strobe),
    .rd_index     (rd_index),
    .rd_data      (rd_data),
    .dbg_rd_index (dbg_rd_index),
    .dbg_rd_data  (dbg_rd_data),
    .v0_data      (v0_data)
  );

  rvv_vrf_wr_arb u_wr_arb (
    .clk          (clk),
    .arst_n       (arst_n),
    .ld_req       (ld_req),
    .ld_index     (ld_wr_index),
    .ld_row       (ld_wr_row),
    .ld_strobe    (ld_wr_strobe),
    .dbg_req      (dbg_req),
    .dbg_index    (dbg_wr_index),
    .dbg_row      (dbg_wr_row),
    .dbg_strobe   (dbg_wr_strobe),
    .ld_gnt       (ld_gnt),
    .dbg_gnt      (dbg_gnt),
    .sh_wr_valid  (sh_wr_valid),
    .sh_wr_index  (sh_wr_index),
    .sh_wr_data   (sh_wr_data),
    .sh_wr_strobe (sh_wr_strobe)
  );

  rvv_vld_wb u_vld_wb (
    .clk      (clk),
    .arst_n   (arst_n),
    .ld_valid (ld_valid),
    .ld_index (ld_index),
    .ld_data  (ld_data),
    .ld_last  (ld_last),
    .ld_ready (ld_ready),
    .req      (ld_req),
    .index    (ld_wr_index),
    .row      (ld_wr_row),
    .strobe   (ld_wr_strobe),
    .gnt      (ld_gnt)
  );

  rvv_vrf_dbg_apb u_dbg_apb (
    .clk      (clk),
    .arst_n   (arst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pstrb    (pstrb),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .rd_index (dbg_rd_index),
    .rd_data  (dbg_rd_data),
    .req      (dbg_req),
    .index    (dbg_wr_index),
    .row      (dbg_wr_row),
    .strobe   (dbg_wr_strobe),
    .gnt      (dbg_gnt)
  );

endmodule

// ==== tb_clk_gen.sv ====
/*
  Testbench clock and reset generator
  Free-running clock and an active-low reset held for a set
  number of cycles
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 20,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

// ==== tb_rvv_vrf_top.sv ====
/*
  Testbench for the VRF subsystem
  Drives retire, dispatch, load and APB ports against a row model
  of the 32 registers and checks every response
*/
`timescale 1ns/1ps

module tb_rvv_vrf_top;

  localparam int NUM_RT   = 4;
  localparam int NUM_RD   = 4;
  localparam int VLEN     = rvv_vrf_cfg_pkg::VLEN;
  localparam int VLENB    = rvv_vrf_cfg_pkg::VLENB;
  localparam int VREG_NUM = rvv_vrf_cfg_pkg::VREG_NUM;
  localparam int IDX_W    = rvv_vrf_cfg_pkg::VREG_IDX_W;
  localparam int WORDS    = rvv_vrf_cfg_pkg::WORDS_PER_ROW;
  // Tests take roughly 200 cycles, so this leaves a wide margin
  localparam int MAX_CYCLES = 4000;

  logic                         clk;
  logic                         arst_n;
  logic [NUM_RT-1:0]            rt_wr_valid;
  logic [NUM_RT-1:0][IDX_W-1:0] rt_wr_index;
  logic [NUM_RT-1:0][VLEN-1:0]  rt_wr_data;
  logic [NUM_RT-1:0][VLENB-1:0] rt_wr_strobe;
  logic [NUM_RD-1:0][IDX_W-1:0] rd_index;
  logic [NUM_RD-1:0][VLEN-1:0]  rd_data;
  logic [VLEN-1:0]              v0_data;
  logic                         ld_valid;
  logic                         ld_ready;
  logic [IDX_W-1:0]             ld_index;
  logic [31:0]                  ld_data;
  logic                         ld_last;
  logic                         psel;
  logic                         penable;
  logic                         pwrite;
  logic [11:0]                  paddr;
  logic [31:0]                  pwdata;
  logic [3:0]                   pstrb;
  logic [31:0]                  prdata;
  logic                         pready;
  logic                         pslverr;

  logic [VLEN-1:0] model [VREG_NUM];
  logic [31:0]     rng_state;
  int              err_cnt;
  int              cycle_cnt = 0;

  tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(8)) u_clk_gen (.clk(clk), .arst_n(arst_n));

  rvv_vrf_top #(
    .NUM_RT (NUM_RT),
    .NUM_RD (NUM_RD)
  ) u_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .rt_wr_valid  (rt_wr_valid),
    .rt_wr_index  (rt_wr_index),
    .rt_wr_data   (rt_wr_data),
    .rt_wr_strobe (rt_wr_strobe),
    .rd_index     (rd_index),
    .rd_data      (rd_data),
    .v0_data      (v0_data),
    .ld_valid     (ld_valid),
    .ld_ready     (ld_ready),
    .ld_index     (ld_index),
    .ld_data      (ld_data),
    .ld_last      (ld_last),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pstrb        (pstrb),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

  // APB responses only in an access cycle
  assert property (@(posedge clk) disable iff (!arst_n) pready |-> (psel && penable))
    else begin
      err_cnt++;
      $display("** Error %0t: pready high outside an APB access cycle", $time);
    end

  assert property (@(posedge clk) disable iff (!arst_n) pslverr |-> pready)
    else begin
      err_cnt++;
      $display("** Error %0t: pslverr high without pready", $time);
    end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Byte-strobed update of one model row
  function automatic logic [VLEN-1:0] merge_row(logic [VLEN-1:0] old_row,
                                                logic [VLEN-1:0] new_row,
                                                logic [VLENB-1:0] strb);
    logic [VLEN-1:0] res;
    res = old_row;
    for (int b = 0; b < VLENB; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_row[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_val(input string what, input logic [VLEN-1:0] got,
                           input logic [VLEN-1:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("** Error %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Read every register on the dispatch ports
  task automatic sweep_regs();
    for (int base = 0; base < VREG_NUM; base += NUM_RD) begin
      @(posedge clk);
      for (int p = 0; p < NUM_RD; p++) begin
        rd_index[p] <= IDX_W'(base + p);
      end
      @(negedge clk);
      for (int p = 0; p < NUM_RD; p++) begin
        check_val($sformatf("rd_data[%0d] of v%0d", p, base + p), rd_data[p],
                  model[base + p]);
      end
      check_val("v0_data", v0_data, model[0]);
    end
  endtask

  // Random retire writes, four distinct registers per cycle
  task automatic retire_burst(input int n);
    logic [31:0]                  rnd;
    logic [IDX_W-1:0]             base;
    logic [NUM_RT-1:0][IDX_W-1:0] idx;
    logic [VLEN-1:0]              data;
    logic [VLENB-1:0]             strb;
    logic                         vld;
    for (int it = 0; it < n; it++) begin
      rnd  = next_rand();
      base = (it == 0) ? '0 : rnd[IDX_W-1:0];
      @(posedge clk);
      for (int p = 0; p < NUM_RT; p++) begin
        idx[p] = base + IDX_W'(p * 7);
        rnd    = next_rand();
        vld    = rnd[0] | rnd[1] | (it == 0);
        strb   = rnd[31:16];
        data   = {next_rand(), next_rand(), next_rand(), next_rand()};
        rt_wr_valid[p]  <= vld;
        rt_wr_index[p]  <= idx[p];
        rt_wr_data[p]   <= data;
        rt_wr_strobe[p] <= strb;
        if (vld) begin
          model[idx[p]] = merge_row(model[idx[p]], data, strb);
        end
      end
      @(posedge clk);
      rt_wr_valid <= '0;
      for (int p = 0; p < NUM_RD; p++) begin
        rd_index[p] <= idx[p];
      end
      @(negedge clk);
      for (int p = 0; p < NUM_RD; p++) begin
        check_val($sformatf("retire readback v%0d", idx[p]), rd_data[p], model[idx[p]]);
      end
      check_val("v0_data after retire", v0_data, model[0]);
    end
  endtask

  task automatic load_row(input logic [IDX_W-1:0] idx, input int nbeats);
    logic [VLEN-1:0]  data;
    logic [VLENB-1:0] strb;
    logic [31:0]      beat;
    int               waits;
    data = '0;
    strb = '0;
    for (int i = 0; i < nbeats; i++) begin
      beat = next_rand();
      data[i*32 +: 32] = beat;
      strb[i*4 +: 4]   = 4'hf;
      @(posedge clk);
      ld_valid <= 1'b1;
      // Only the first beat's index counts
      ld_index <= (i == 0) ? idx : ~idx;
      ld_data  <= beat;
      ld_last  <= (nbeats < WORDS) && (i == nbeats - 1);
      do @(negedge clk); while (!ld_ready);
    end
    @(posedge clk);
    ld_valid <= 1'b0;
    ld_last  <= 1'b0;
    waits = 0;
    @(negedge clk);
    while (!ld_ready) begin
      waits++;
      @(negedge clk);
    end
    assert (waits >= 1 && waits <= 2) else begin
      err_cnt++;
      $display("** Error %0t: ld_ready low for %0d cycles after the row", $time, waits);
    end
    model[idx] = merge_row(model[idx], data, strb);
    check_val("v0_data after load", v0_data, model[0]);
  endtask

  task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, input logic exp_err);
    logic [IDX_W-1:0] idx;
    int               wsel;
    int               waits;
    idx  = addr[8:4];
    wsel = int'(addr[3:2]);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    pstrb   <= strb;
    @(posedge clk);
    penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    // At most one lost tie before the grant
    assert (waits <= 1) else begin
      err_cnt++;
      $display("** Error %0t: APB access took %0d wait cycles", $time, waits);
    end
    check_val("pslverr", VLEN'(pslverr), VLEN'(exp_err));
    if (!exp_err && !wr) begin
      check_val("prdata", VLEN'(prdata), VLEN'(model[idx][wsel*32 +: 32]));
    end
    if (!exp_err && wr) begin
      model[idx] = merge_row(model[idx], VLEN'(wdata) << (wsel * 32),
                             VLENB'(strb) << (wsel * 4));
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    @(negedge clk);
    check_val("v0_data after APB", v0_data, model[0]);
  endtask

  // Load row and APB write reach the arbiter in the same cycle
  task automatic contend(input logic [IDX_W-1:0] ld_idx, input logic [11:0] addr);
    fork
      load_row(ld_idx, WORDS);
      begin
        repeat (3) @(posedge clk);
        apb_xfer(1'b1, addr, next_rand(), 4'hf, 1'b0);
      end
    join
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rng_state    = 32'hc976_f839;
    err_cnt      = 0;
    rt_wr_valid  = '0;
    rt_wr_index  = '0;
    rt_wr_data   = '0;
    rt_wr_strobe = '0;
    rd_index     = '0;
    ld_valid     = 1'b0;
    ld_index     = '0;
    ld_data      = '0;
    ld_last      = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    pstrb        = '0;
    for (int r = 0; r < VREG_NUM; r++) begin
      model[r] = '0;
    end
    wait (arst_n === 1'b1);

    // Reset state
    @(negedge clk);
    check_val("ld_ready after reset", VLEN'(ld_ready), VLEN'(1'b1));
    check_val("pready after reset", VLEN'(pready), '0);
    check_val("pslverr after reset", VLEN'(pslverr), '0);
    check_val("load grant after reset", VLEN'(u_dut.ld_gnt), '0);
    check_val("debug grant after reset", VLEN'(u_dut.dbg_gnt), '0);
    sweep_regs();
    apb_xfer(1'b0, 12'h1fc, '0, '0, 1'b0);

    retire_burst(24);
    sweep_regs();

    load_row(5'd7, 4);
    load_row(5'd7, 2);
    load_row(5'd0, 3);
    sweep_regs();

    apb_xfer(1'b1, 12'h058, next_rand(), 4'b0101, 1'b0);
    apb_xfer(1'b0, 12'h058, '0, '0, 1'b0);
    apb_xfer(1'b1, 12'h004, next_rand(), 4'b1000, 1'b0);
    apb_xfer(1'b1, 12'h200, next_rand(), 4'hf, 1'b1);
    apb_xfer(1'b0, 12'h7fc, '0, '0, 1'b1);
    sweep_regs();

    // Two ties so each peer wins one
    contend(5'd12, 12'h1a8);
    // Load owns the port last so debug wins the next tie
    load_row(5'd3, 1);
    contend(5'd19, 12'h0c4);
    sweep_regs();

    $display("Checks finished with %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== rvv_vrf.f ====
rvv_vrf_cfg_pkg.sv
rvv_vrf_dbg_pkg.sv
rvv_vrf_reg.sv
rvv_vrf.sv
rvv_vrf_wr_arb.sv
rvv_vld_wb.sv
rvv_vrf_dbg_apb.sv
rvv_vrf_top.sv
tb_clk_gen.sv
tb_rvv_vrf_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the VRF testbench with Verilator and run it.
# Exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rvv_vrf_top \
  -f rvv_vrf.f \
  -o sim_rvv_vrf \
  && ./obj_dir/sim_rvv_vrf | tee /dev/stderr | grep -F -q "TEST RESULT: PASS" \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }
